/* design/mailbox_pkg.sv */
// shared types, address map and FSM encoding for the mailbox controller; compile first
package mailbox_pkg;

    // ----------------------------------------------------------
    // widths that carry a meaning
    // ----------------------------------------------------------
    typedef logic [14:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  ss_user_t;
    typedef logic [27:0] ss_addr_t;
    typedef logic [2:0]  mb_index_t;

    // ----------------------------------------------------------
    // address map
    // ----------------------------------------------------------
    localparam addr_t mb_low    = 15'h2000;
    localparam addr_t mb_high   = 15'h201F;
    localparam addr_t ctrl_low  = 15'h2100;
    localparam addr_t ctrl_high = 15'h2107;

    // two-beat remote write tag
    localparam ss_user_t ss_user_write = 2'b01;
    localparam data_t    all_ones      = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {
        dest_mailbox,
        dest_control,
        dest_bad_read,
        dest_ignore
    } dest_e;

    typedef enum logic [2:0] {
        st_wait_req,
        st_fetch,
        st_decide,
        st_ss_second,
        st_move,
        st_raise_int
    } txn_state_e;

    // rd_wr is 1 for a read
    typedef struct packed {
        logic  rd_wr;
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
    } ls_req_t;

    typedef struct packed {
        data_t    data;
        ss_user_t user;
    } ss_beat_t;

    typedef struct packed {
        strb_t    strb;
        ss_addr_t addr;
        data_t    data;
    } ss_write_t;

    typedef struct packed {
        dest_e     dest;
        logic      is_write;
        mb_index_t mb_index;
        logic      ctrl_index;
        data_t     wdata;
        strb_t     wstrb;
    } reg_cmd_t;

endpackage

/* design/beat_gap_timer.sv */
// gap counter between the two SS beats; start on the first beat, gap_done allows the second
module beat_gap_timer #(
    parameter int unsigned ss_gap_cycles = 3
) (
    input  logic axi_aclk,
    input  logic axi_aresetn,
    input  logic start,
    output logic gap_done
);

    localparam int unsigned cnt_w = $clog2(ss_gap_cycles + 2);
    localparam logic [cnt_w-1:0] gap_limit = cnt_w'(ss_gap_cycles);

    logic [cnt_w-1:0] count;

    // the start cycle counts as the first one
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            count <= '0;
        end else if (start) begin
            count <= cnt_w'(1);
        end else if (count < gap_limit) begin
            count <= count + cnt_w'(1);
        end
    end

    // saturates until the next start
    assign gap_done = (count >= gap_limit);

endmodule

/* design/ss_beat_capture.sv */
// holds the two beats of a remote SS write and presents them as one write command
module ss_beat_capture (
    input  logic                   axi_aclk,
    input  logic                   axi_aresetn,
    input  mailbox_pkg::ss_beat_t  ss_beat,
    input  logic                   cap_first,
    input  logic                   cap_second,
    output mailbox_pkg::ss_user_t  first_user,
    output mailbox_pkg::ss_write_t ss_write
);

    mailbox_pkg::data_t first_data;
    mailbox_pkg::data_t second_data;

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            first_data  <= '0;
            first_user  <= '0;
            second_data <= '0;
        end else begin
            if (cap_first) begin
                first_data <= ss_beat.data;
                first_user <= ss_beat.user;
            end
            if (cap_second) begin
                second_data <= ss_beat.data;
            end
        end
    end

    // first beat is strobe in 31:28 over address in 27:0
    assign ss_write.strb = first_data[31:28];
    assign ss_write.addr = first_data[27:0];
    assign ss_write.data = second_data;

endmodule

/* design/addr_decode.sv */
// address decoder; maps the selected LS or SS request onto a register command
module addr_decode (
    input  logic                   sel_ss,
    input  mailbox_pkg::ls_req_t   ls_req,
    input  mailbox_pkg::ss_write_t ss_write,
    output mailbox_pkg::reg_cmd_t  cmd,
    output logic                   ls_is_read
);

    logic ls_in_mb;
    logic ls_in_ctrl;
    logic ss_in_mb;

    assign ls_is_read = ls_req.rd_wr;

    assign ls_in_mb   = (ls_req.addr >= mailbox_pkg::mb_low)
                     && (ls_req.addr <= mailbox_pkg::mb_high);
    assign ls_in_ctrl = (ls_req.addr >= mailbox_pkg::ctrl_low)
                     && (ls_req.addr <= mailbox_pkg::ctrl_high);
    // remote address is wider, compare against the zero-extended map
    assign ss_in_mb   = (ss_write.addr >= mailbox_pkg::ss_addr_t'(mailbox_pkg::mb_low))
                     && (ss_write.addr <= mailbox_pkg::ss_addr_t'(mailbox_pkg::mb_high));

    always_comb begin
        cmd = '0;
        if (sel_ss) begin
            // remote side only ever writes the mailbox
            cmd.is_write = 1'b1;
            cmd.mb_index = ss_write.addr[4:2];
            cmd.wdata    = ss_write.data;
            cmd.wstrb    = ss_write.strb;
            cmd.dest     = ss_in_mb ? mailbox_pkg::dest_mailbox : mailbox_pkg::dest_ignore;
        end else begin
            cmd.is_write   = !ls_req.rd_wr;
            cmd.mb_index   = ls_req.addr[4:2];
            cmd.ctrl_index = ls_req.addr[2];
            cmd.wdata      = ls_req.wdata;
            cmd.wstrb      = ls_req.wstrb;
            if (ls_in_mb) begin
                cmd.dest = mailbox_pkg::dest_mailbox;
            end else if (ls_in_ctrl) begin
                cmd.dest = mailbox_pkg::dest_control;
            end else if (ls_req.rd_wr) begin
                cmd.dest = mailbox_pkg::dest_bad_read;
            end else begin
                cmd.dest = mailbox_pkg::dest_ignore;
            end
        end
    end

endmodule

/* design/mailbox_regs.sv */
// mailbox words, interrupt enable and status, read data register and interrupt output
module mailbox_regs (
    input  logic                  axi_aclk,
    input  logic                  axi_aresetn,
    input  logic                  reg_exec,
    input  logic                  reg_set_int,
    input  mailbox_pkg::reg_cmd_t cmd,
    output mailbox_pkg::data_t    rdata,
    output logic                  irq
);

    mailbox_pkg::data_t mb_words [8];
    mailbox_pkg::data_t read_word;
    logic               int_en;
    logic               int_status;
    logic               mb_write;
    logic               ctrl_write;

    assign mb_write   = reg_exec && cmd.is_write && (cmd.dest == mailbox_pkg::dest_mailbox);
    assign ctrl_write = reg_exec && cmd.is_write && (cmd.dest == mailbox_pkg::dest_control);

    // ----------------------------------------------------------
    // mailbox words, byte strobed
    // ----------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            for (int i = 0; i < 8; i++) begin
                mb_words[i] <= '0;
            end
        end else if (mb_write) begin
            for (int b = 0; b < 4; b++) begin
                if (cmd.wstrb[b]) begin
                    mb_words[cmd.mb_index][8*b +: 8] <= cmd.wdata[8*b +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------
    // control registers
    // ----------------------------------------------------------
    // offset 0 bit 0 is enable, offset 4 bit 0 is status
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            int_en     <= 1'b0;
            int_status <= 1'b0;
        end else begin
            if (ctrl_write && !cmd.ctrl_index && cmd.wstrb[0]) begin
                int_en <= cmd.wdata[0];
            end
            if (reg_set_int) begin
                int_status <= 1'b1;
            end else if (ctrl_write && cmd.ctrl_index && cmd.wstrb[0] && cmd.wdata[0]) begin
                // write one to clear
                int_status <= 1'b0;
            end
        end
    end

    // read mux, anything unmapped reads as all ones
    always_comb begin
        case (cmd.dest)
            mailbox_pkg::dest_mailbox: begin
                read_word = mb_words[cmd.mb_index];
            end
            mailbox_pkg::dest_control: begin
                read_word = {31'b0, cmd.ctrl_index ? int_status : int_en};
            end
            default: begin
                read_word = mailbox_pkg::all_ones;
            end
        endcase
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            rdata <= '0;
        end else if (reg_exec && !cmd.is_write) begin
            rdata <= read_word;
        end
    end

    assign irq = int_en && int_status;

endmodule

/* design/txn_fsm.sv */
// transaction FSM of the mailbox controller; arbitrates LS and SS and issues every strobe
module txn_fsm #(
    parameter int unsigned ss_gap_cycles = 3
) (
    input  logic                  axi_aclk,
    input  logic                  axi_aresetn,
    input  logic                  ls_valid,
    input  logic                  ss_valid,
    input  mailbox_pkg::ss_user_t ss_user,
    input  mailbox_pkg::dest_e    dest,
    input  logic                  gap_done,
    input  logic                  ls_is_read,
    output logic                  sel_ss,
    output logic                  cap_first,
    output logic                  cap_second,
    output logic                  timer_start,
    output logic                  reg_exec,
    output logic                  reg_set_int,
    output logic                  ls_ready,
    output logic                  ss_ready
);

    // with no gap the timer is not waited on
    localparam logic gap_needed = (ss_gap_cycles > 0);

    mailbox_pkg::txn_state_e state;
    mailbox_pkg::txn_state_e state_next;
    logic                    last_ss;
    logic                    pick_ss;
    logic                    ss_two_beat;
    logic                    second_ok;
    logic                    any_valid;

    assign any_valid   = ls_valid || ss_valid;
    // round robin, the source not served last wins a tie
    assign pick_ss     = ss_valid && (!ls_valid || !last_ss);
    assign ss_two_beat = (ss_user == mailbox_pkg::ss_user_write);
    assign second_ok   = ss_valid && (gap_done || !gap_needed);

    // ----------------------------------------------------------
    // state and source selection
    // ----------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state <= mailbox_pkg::st_wait_req;
        end else begin
            state <= state_next;
        end
    end

    // last_ss starts high so LS is favored first
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            sel_ss  <= 1'b0;
            last_ss <= 1'b1;
        end else if (state == mailbox_pkg::st_wait_req && any_valid) begin
            sel_ss  <= pick_ss;
            last_ss <= pick_ss;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            mailbox_pkg::st_wait_req: begin
                if (any_valid) begin
                    state_next = mailbox_pkg::st_fetch;
                end
            end
            mailbox_pkg::st_fetch: begin
                state_next = mailbox_pkg::st_decide;
            end
            mailbox_pkg::st_decide: begin
                if (!sel_ss) begin
                    state_next = mailbox_pkg::st_move;
                end else if (ss_two_beat) begin
                    state_next = mailbox_pkg::st_ss_second;
                end else begin
                    // other tags are dropped after the first beat
                    state_next = mailbox_pkg::st_wait_req;
                end
            end
            mailbox_pkg::st_ss_second: begin
                if (second_ok) begin
                    state_next = mailbox_pkg::st_move;
                end
            end
            mailbox_pkg::st_move: begin
                if (sel_ss && dest == mailbox_pkg::dest_mailbox) begin
                    state_next = mailbox_pkg::st_raise_int;
                end else begin
                    state_next = mailbox_pkg::st_wait_req;
                end
            end
            mailbox_pkg::st_raise_int: begin
                state_next = mailbox_pkg::st_wait_req;
            end
            default: begin
                state_next = mailbox_pkg::st_wait_req;
            end
        endcase
    end

    // ----------------------------------------------------------
    // strobes
    // ----------------------------------------------------------
    assign cap_first   = (state == mailbox_pkg::st_fetch) && sel_ss;
    assign cap_second  = (state == mailbox_pkg::st_ss_second) && second_ok;
    assign timer_start = (state == mailbox_pkg::st_decide) && sel_ss && ss_two_beat;
    assign reg_set_int = (state == mailbox_pkg::st_raise_int);
    assign ls_ready    = (state == mailbox_pkg::st_move) && !sel_ss;

    // first beat in decide, second beat once the gap has run out
    assign ss_ready = ((state == mailbox_pkg::st_decide) && sel_ss) || cap_second;

    // an LS read loads rdata one cycle early so it is valid with ls_ready
    assign reg_exec = ((state == mailbox_pkg::st_decide) && !sel_ss && ls_is_read)
                   || ((state == mailbox_pkg::st_move) && (sel_ss || !ls_is_read));

endmodule

/* design/mailbox_ctrl_top.sv */
// mailbox controller top level; instantiate this and set ss_gap_cycles for the SS beat gap
module mailbox_ctrl_top #(
    parameter int unsigned ss_gap_cycles = 3
) (
    input  logic                   axi_aclk,
    input  logic                   axi_aresetn,
    // local register port
    input  logic                   ls_valid,
    input  mailbox_pkg::ls_req_t   ls_req,
    output logic                   ls_ready,
    output mailbox_pkg::data_t     ls_rdata,
    // remote stream port
    input  logic                   ss_valid,
    input  mailbox_pkg::ss_beat_t  ss_beat,
    output logic                   ss_ready,
    output logic                   irq
);

    logic                   sel_ss;
    logic                   cap_first;
    logic                   cap_second;
    logic                   timer_start;
    logic                   gap_done;
    logic                   reg_exec;
    logic                   reg_set_int;
    logic                   ls_is_read;
    mailbox_pkg::ss_user_t  first_user;
    mailbox_pkg::ss_write_t ss_write;
    mailbox_pkg::reg_cmd_t  cmd;

    txn_fsm #(
        .ss_gap_cycles (ss_gap_cycles)
    ) u_txn_fsm (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .ls_valid    (ls_valid),
        .ss_valid    (ss_valid),
        .ss_user     (first_user),
        .dest        (cmd.dest),
        .gap_done    (gap_done),
        .ls_is_read  (ls_is_read),
        .sel_ss      (sel_ss),
        .cap_first   (cap_first),
        .cap_second  (cap_second),
        .timer_start (timer_start),
        .reg_exec    (reg_exec),
        .reg_set_int (reg_set_int),
        .ls_ready    (ls_ready),
        .ss_ready    (ss_ready)
    );

    beat_gap_timer #(
        .ss_gap_cycles (ss_gap_cycles)
    ) u_beat_gap_timer (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .start       (timer_start),
        .gap_done    (gap_done)
    );

    ss_beat_capture u_ss_beat_capture (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .ss_beat     (ss_beat),
        .cap_first   (cap_first),
        .cap_second  (cap_second),
        .first_user  (first_user),
        .ss_write    (ss_write)
    );

    addr_decode u_addr_decode (
        .sel_ss      (sel_ss),
        .ls_req      (ls_req),
        .ss_write    (ss_write),
        .cmd         (cmd),
        .ls_is_read  (ls_is_read)
    );

    mailbox_regs u_mailbox_regs (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .reg_exec    (reg_exec),
        .reg_set_int (reg_set_int),
        .cmd         (cmd),
        .rdata       (ls_rdata),
        .irq         (irq)
    );

endmodule

/* tb/mailbox_ctrl_sva.sv */
// handshake and interrupt assertions for the mailbox controller; bound into the top level
module mailbox_ctrl_sva #(
    parameter int unsigned ss_gap_cycles = 3
) (
    input logic                  axi_aclk,
    input logic                  axi_aresetn,
    input logic                  ls_valid,
    input mailbox_pkg::ls_req_t  ls_req,
    input logic                  ls_ready,
    input logic                  ss_valid,
    input mailbox_pkg::ss_beat_t ss_beat,
    input logic                  ss_ready,
    input logic                  irq
);
    timeunit 1ns;
    timeprecision 1ps;

    // cycles since the first beat of a remote write was accepted
    int unsigned since_first;
    logic        second_pending;
    // enable bit as last written over the LS port
    logic        en_seen;
    logic        en_write;
    int unsigned assert_fails = 0;

    assign en_write = ls_valid && ls_ready && !ls_req.rd_wr && ls_req.wstrb[0]
                   && (ls_req.addr >= mailbox_pkg::ctrl_low)
                   && (ls_req.addr <= mailbox_pkg::ctrl_high)
                   && !ls_req.addr[2];

    // first and second beat alternate, only tag 01 opens a two-beat write
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            second_pending <= 1'b0;
            since_first    <= 0;
        end else if (ss_valid && ss_ready) begin
            if (second_pending) begin
                second_pending <= 1'b0;
            end else if (ss_beat.user == mailbox_pkg::ss_user_write) begin
                second_pending <= 1'b1;
                since_first    <= 1;
            end
        end else if (since_first <= ss_gap_cycles) begin
            since_first <= since_first + 1;
        end
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            en_seen <= 1'b0;
        end else if (en_write) begin
            en_seen <= ls_req.wdata[0];
        end
    end

    // ----------------------------------------------------------
    // properties
    // ----------------------------------------------------------
    ls_ready_pulse: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        ls_ready |=> !ls_ready)
        else begin
            assert_fails++;
            $error("ls_ready stayed high for more than one cycle");
        end

    ss_ready_pulse: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        ss_ready |=> !ss_ready)
        else begin
            assert_fails++;
            $error("ss_ready stayed high for more than one cycle");
        end

    second_beat_gap: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (ss_valid && ss_ready && second_pending) |-> (since_first >= ss_gap_cycles))
        else begin
            assert_fails++;
            $error("second SS beat accepted before the minimum gap");
        end

    irq_needs_enable: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        !en_seen |-> !irq)
        else begin
            assert_fails++;
            $error("irq high while the interrupt enable bit is clear");
        end

endmodule

bind mailbox_ctrl_top mailbox_ctrl_sva #(
    .ss_gap_cycles (ss_gap_cycles)
) u_sva (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .ls_valid    (ls_valid),
    .ls_req      (ls_req),
    .ls_ready    (ls_ready),
    .ss_valid    (ss_valid),
    .ss_beat     (ss_beat),
    .ss_ready    (ss_ready),
    .irq         (irq)
);

/* tb/mailbox_ctrl_tb.sv */
// self-checking testbench for the mailbox controller; simulate with mailbox_ctrl_tb as top
module mailbox_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned ss_gap_cycles   = 3;
    localparam int          num_tests       = 6;
    localparam int          watchdog_cycles = num_tests * 200;

    logic                  axi_aclk;
    logic                  axi_aresetn;
    logic                  ls_valid;
    mailbox_pkg::ls_req_t  ls_req;
    logic                  ls_ready;
    mailbox_pkg::data_t    ls_rdata;
    logic                  ss_valid;
    mailbox_pkg::ss_beat_t ss_beat;
    logic                  ss_ready;
    logic                  irq;

    // reference model state
    mailbox_pkg::data_t model_mb [8];
    logic               model_en;
    logic               model_status;

    logic [31:0] rand_state;
    string       test_name;
    int          err_count;
    int          check_count;
    int          tests_failed;
    int          test_err_start;

    mailbox_ctrl_top #(
        .ss_gap_cycles (ss_gap_cycles)
    ) uut (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .ls_valid    (ls_valid),
        .ls_req      (ls_req),
        .ls_ready    (ls_ready),
        .ls_rdata    (ls_rdata),
        .ss_valid    (ss_valid),
        .ss_beat     (ss_beat),
        .ss_ready    (ss_ready),
        .irq         (irq)
    );

    initial begin
        axi_aclk = 1'b0;
        forever #50 axi_aclk = ~axi_aclk;
    end

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic mailbox_pkg::data_t merge_bytes(mailbox_pkg::data_t old_word,
            mailbox_pkg::data_t new_word, mailbox_pkg::strb_t strb);
        mailbox_pkg::data_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    function automatic mailbox_pkg::data_t ref_read(mailbox_pkg::addr_t addr);
        if (addr >= 15'h2000 && addr <= 15'h201F) begin
            return model_mb[addr[4:2]];
        end else if (addr >= 15'h2100 && addr <= 15'h2107) begin
            return {31'b0, addr[2] ? model_status : model_en};
        end
        return 32'hFFFF_FFFF;
    endfunction

    function automatic logic ref_irq();
        return model_en && model_status;
    endfunction

    function automatic void model_ls_write(mailbox_pkg::addr_t addr,
            mailbox_pkg::data_t wdata, mailbox_pkg::strb_t wstrb);
        if (addr >= 15'h2000 && addr <= 15'h201F) begin
            model_mb[addr[4:2]] = merge_bytes(model_mb[addr[4:2]], wdata, wstrb);
        end else if (addr >= 15'h2100 && addr <= 15'h2107 && wstrb[0]) begin
            if (!addr[2]) begin
                model_en = wdata[0];
            end else if (wdata[0]) begin
                model_status = 1'b0;
            end
        end
    endfunction

    function automatic void model_ss_write(mailbox_pkg::ss_addr_t addr,
            mailbox_pkg::data_t wdata, mailbox_pkg::strb_t wstrb);
        if (addr >= 28'h2000 && addr <= 28'h201F) begin
            model_mb[addr[4:2]] = merge_bytes(model_mb[addr[4:2]], wdata, wstrb);
            model_status = 1'b1;
        end
    endfunction

    function automatic mailbox_pkg::addr_t mb_addr(int i);
        return 15'h2000 + 15'(i * 4);
    endfunction

    // ----------------------------------------------------------
    // checks and bookkeeping
    // ----------------------------------------------------------
    task automatic check_data(string name, mailbox_pkg::data_t exp, mailbox_pkg::data_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_irq(string name, logic exp, logic act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("CHECK FAILED %s irq: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic begin_test(string name);
        test_name      = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        if (err_count == test_err_start) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, err_count - test_err_start);
        end
    endtask

    // every accepted LS read is compared against the model
    always @(posedge axi_aclk) begin
        if (axi_aresetn && ls_valid && ls_ready && ls_req.rd_wr) begin
            check_data($sformatf("%s read %h", test_name, ls_req.addr),
                       ref_read(ls_req.addr), ls_rdata);
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge axi_aclk);
        $display("watchdog expired after %0d cycles, a handshake never completed",
                 watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    // ----------------------------------------------------------
    // bus drivers
    // ----------------------------------------------------------
    task automatic ls_access(logic rd, mailbox_pkg::addr_t addr, mailbox_pkg::data_t wdata,
            mailbox_pkg::strb_t wstrb);
        @(posedge axi_aclk);
        ls_valid     <= 1'b1;
        ls_req.rd_wr <= rd;
        ls_req.addr  <= addr;
        ls_req.wdata <= wdata;
        ls_req.wstrb <= wstrb;
        do begin
            @(posedge axi_aclk);
        end while (!ls_ready);
        ls_valid <= 1'b0;
        if (!rd) begin
            model_ls_write(addr, wdata, wstrb);
        end
    endtask

    task automatic ls_read(mailbox_pkg::addr_t addr);
        ls_access(1'b1, addr, '0, '0);
    endtask

    task automatic ls_write(mailbox_pkg::addr_t addr, mailbox_pkg::data_t wdata,
            mailbox_pkg::strb_t wstrb);
        ls_access(1'b0, addr, wdata, wstrb);
    endtask

    task automatic wait_ss_ready();
        do begin
            @(posedge axi_aclk);
        end while (!ss_ready);
    endtask

    // idle is the number of cycles without valid before the second beat
    task automatic ss_send(mailbox_pkg::ss_user_t tag, mailbox_pkg::ss_addr_t addr,
            mailbox_pkg::data_t wdata, mailbox_pkg::strb_t wstrb, int idle);
        @(posedge axi_aclk);
        ss_valid     <= 1'b1;
        ss_beat.data <= {wstrb, addr};
        ss_beat.user <= tag;
        wait_ss_ready();
        if (tag == 2'b01) begin
            if (idle > 0) begin
                ss_valid <= 1'b0;
                repeat (idle) @(posedge axi_aclk);
            end
            ss_valid     <= 1'b1;
            ss_beat.data <= wdata;
            wait_ss_ready();
            model_ss_write(addr, wdata, wstrb);
        end
        ss_valid <= 1'b0;
    endtask

    task automatic irq_check_settled();
        @(posedge axi_aclk);
        check_irq(test_name, ref_irq(), irq);
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < 8; i++) begin
            ls_read(mb_addr(i));
        end
        ls_read(15'h2100);
        ls_read(15'h2104);
    endtask

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin
        mailbox_pkg::data_t wdata;
        logic [31:0]        r;
        logic               ls_first;
        logic               ss_done;

        axi_aresetn  = 1'b0;
        ls_valid     = 1'b0;
        ls_req       = '0;
        ss_valid     = 1'b0;
        ss_beat      = '0;
        rand_state   = 32'h877c;
        model_en     = 1'b0;
        model_status = 1'b0;
        err_count    = 0;
        check_count  = 0;
        tests_failed = 0;
        test_name    = "reset";
        for (int i = 0; i < 8; i++) begin
            model_mb[i] = '0;
        end
        repeat (10) @(posedge axi_aclk);
        axi_aresetn <= 1'b1;

        // both sources at once straight after reset, LS must win
        begin_test("arbitration");
        ls_first = 1'b0;
        ss_done  = 1'b0;
        wdata    = next_rand();
        fork
            begin
                ls_read(15'h2008);
                ls_first = !ss_done;
            end
            begin
                ss_send(2'b01, 28'h0002008, wdata, 4'hF, 0);
                ss_done = 1'b1;
            end
        join
        check_count++;
        if (!ls_first) begin
            err_count++;
            $display("arbitration: the SS write was served before the first LS read");
        end
        ls_read(15'h2008);
        end_test();

        begin_test("mailbox_rw");
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 8; i++) begin
                wdata = next_rand();
                r     = next_rand();
                ls_write(mb_addr(i), wdata, r[7:4]);
            end
        end
        for (int i = 0; i < 8; i++) begin
            ls_read(mb_addr(i));
        end
        end_test();

        // status is still set by the remote write above
        begin_test("control");
        ls_write(15'h2104, 32'h0, 4'hF);
        ls_read(15'h2104);
        ls_write(15'h2104, 32'h1, 4'hF);
        ls_read(15'h2104);
        ls_write(15'h2100, 32'h1, 4'h1);
        ls_read(15'h2100);
        irq_check_settled();
        ls_write(15'h2104, 32'h0, 4'hF);
        ls_read(15'h2104);
        irq_check_settled();
        end_test();

        begin_test("unmapped");
        ls_read(15'h2020);
        ls_read(15'h2108);
        ls_read(15'h2FFC);
        ls_read(15'h0000);
        ls_read(15'h7FFC);
        ls_write(15'h2020, next_rand(), 4'hF);
        ls_write(15'h2108, 32'hFFFF_FFFF, 4'hF);
        ls_write(15'h7FFC, next_rand(), 4'hF);
        read_all_regs();
        irq_check_settled();
        end_test();

        begin_test("remote_write");
        wdata = next_rand();
        r     = next_rand();
        ss_send(2'b01, 28'h0002004, wdata, r[3:0], 2);
        ls_read(15'h2004);
        ls_read(15'h2104);
        irq_check_settled();
        ls_write(15'h2104, 32'h1, 4'h1);
        irq_check_settled();
        ss_send(2'b01, 28'h000201C, next_rand(), 4'hF, 0);
        ls_read(15'h201C);
        ls_write(15'h2104, 32'h1, 4'h1);
        // misses of the mailbox range
        ss_send(2'b01, 28'h0002100, next_rand(), 4'hF, 1);
        ss_send(2'b01, 28'hA002004, next_rand(), 4'hF, 0);
        read_all_regs();
        irq_check_settled();
        end_test();

        begin_test("bad_tag");
        ss_send(2'b00, 28'h0002008, next_rand(), 4'hF, 0);
        ss_send(2'b10, 28'h000200C, next_rand(), 4'hF, 0);
        ss_send(2'b11, 28'h0002010, next_rand(), 4'hF, 0);
        read_all_regs();
        irq_check_settled();
        end_test();

        err_count += uut.u_sva.assert_fails;
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 num_tests, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* Bender.yml */
package:
  name: mailbox_ctrl

sources:
  - design/mailbox_pkg.sv
  - design/beat_gap_timer.sv
  - design/ss_beat_capture.sv
  - design/addr_decode.sv
  - design/mailbox_regs.sv
  - design/txn_fsm.sv
  - design/mailbox_ctrl_top.sv
  - target: test
    files:
      - tb/mailbox_ctrl_sva.sv
      - tb/mailbox_ctrl_tb.sv

/* compile.f */
design/mailbox_pkg.sv
design/beat_gap_timer.sv
design/ss_beat_capture.sv
design/addr_decode.sv
design/mailbox_regs.sv
design/txn_fsm.sv
design/mailbox_ctrl_top.sv
tb/mailbox_ctrl_sva.sv
tb/mailbox_ctrl_tb.sv
